// File: files.f
+incdir+testbench
hdl/armCtrlPkg.sv
hdl/instrDecoder.sv
hdl/condUnit.sv
hdl/executeStage.sv
hdl/memWbStages.sv
hdl/armController.sv
testbench/armCtrl_asserts.sv
testbench/tbArmController.sv

// File: hdl/armController.sv
`timescale 1ns/10ps

module armController (
  input  logic                 clk,
  input  logic                 rst,
  // Datapath inputs
  input  armCtrlPkg::instrT    instrD,
  input  armCtrlPkg::flagsT    aluFlagsE,
  input  logic                 shifterCarryE,
  input  logic [1:0]           aluResultE,    // Address low bits
  // Hazard unit
  input  logic                 stallE, stallM, stallW,
  input  logic                 flushE, flushM, flushW,
  // Decode outputs
  output armCtrlPkg::srcSelT   regSrcD, immSrcD,
  output logic                 aluSrcD,
  // Execute outputs
  output logic                 branchTakenE,
  output armCtrlPkg::aluCtrlT  aluControlE,
  output logic                 aluSrcE,
  output armCtrlPkg::flagsT    flagsE,
  // Memory outputs
  output logic                 memWriteM, regWriteM, memtoRegM,
  output armCtrlPkg::byteMaskT byteMaskM,
  // Writeback outputs
  output logic                 regWriteW, memtoRegW, pcSrcW, loadByteW,
  output logic [1:0]           byteOffsetW
);

  armCtrlPkg::decodeCtrlT ctrlD;
  armCtrlPkg::memCtrlT    ctrlE;

  // ==================================================
  // Decode, Execute, Memory / Writeback
  // ==================================================
  instrDecoder uDecoder (
    .instrD  (instrD),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD),
    .aluSrcD (aluSrcD),
    .ctrlD   (ctrlD)
  );

  executeStage uExecute (
    .clk           (clk),
    .rst           (rst),
    .stallE        (stallE),
    .flushE        (flushE),
    .ctrlD         (ctrlD),
    .flagsE        (flagsE),        // Loops back from memWb forwarding
    .aluFlagsE     (aluFlagsE),
    .shifterCarryE (shifterCarryE),
    .aluAddrE      (aluResultE),
    .aluControlE   (aluControlE),
    .aluSrcE       (aluSrcE),
    .branchTakenE  (branchTakenE),
    .ctrlE         (ctrlE)
  );

  memWbStages uMemWb (
    .clk (clk), .rst (rst),
    .stallM (stallM), .flushM (flushM), .stallW (stallW), .flushW (flushW),
    .ctrlE (ctrlE),
    .memWriteM (memWriteM), .regWriteM (regWriteM), .memtoRegM (memtoRegM),
    .byteMaskM (byteMaskM),
    .regWriteW (regWriteW), .memtoRegW (memtoRegW), .pcSrcW (pcSrcW),
    .loadByteW (loadByteW), .byteOffsetW (byteOffsetW),
    .flagsE (flagsE)
  );

endmodule

// File: hdl/armCtrlPkg.sv
package armCtrlPkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int instrWidth = 32;

  typedef logic [instrWidth-1:0] instrT;   // Raw instruction word
  typedef logic [3:0]            condT;    // Condition field, instr[31:28]
  typedef logic [3:0]            flagsT;   // NZCV, N on top
  typedef logic [3:0]            aluCtrlT; // Data-processing opcode to ALU
  typedef logic [3:0]            byteMaskT; // One enable per byte lane
  typedef logic [1:0]            srcSelT;  // Register / immediate source select

  // Flag bit positions inside flagsT
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  // Data-processing opcodes, instr[24:21]
  localparam aluCtrlT opAnd = 4'h0;
  localparam aluCtrlT opEor = 4'h1;
  localparam aluCtrlT opSub = 4'h2;
  localparam aluCtrlT opRsb = 4'h3;
  localparam aluCtrlT opAdd = 4'h4;
  localparam aluCtrlT opAdc = 4'h5;
  localparam aluCtrlT opSbc = 4'h6;
  localparam aluCtrlT opRsc = 4'h7;
  localparam aluCtrlT opTst = 4'h8;
  localparam aluCtrlT opTeq = 4'h9;
  localparam aluCtrlT opCmp = 4'hA;
  localparam aluCtrlT opCmn = 4'hB;
  localparam aluCtrlT opOrr = 4'hC;
  localparam aluCtrlT opMov = 4'hD;
  localparam aluCtrlT opBic = 4'hE;
  localparam aluCtrlT opMvn = 4'hF;

  // Condition codes, 4'hF is never
  localparam condT condEq = 4'h0;
  localparam condT condNe = 4'h1;
  localparam condT condCs = 4'h2;
  localparam condT condCc = 4'h3;
  localparam condT condMi = 4'h4;
  localparam condT condPl = 4'h5;
  localparam condT condVs = 4'h6;
  localparam condT condVc = 4'h7;
  localparam condT condHi = 4'h8;
  localparam condT condLs = 4'h9;
  localparam condT condGe = 4'hA;
  localparam condT condLt = 4'hB;
  localparam condT condGt = 4'hC;
  localparam condT condLe = 4'hD;
  localparam condT condAl = 4'hE;

  // ==================================================
  // Stage control words
  // ==================================================
  typedef struct packed {
    logic       aluSrc;      // 1 = immediate operand B
    aluCtrlT    aluControl;
    logic [1:0] flagWrite;   // [1] NZ, [0] CV
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       branch;
    logic       pcSrc;       // Writes R15
    logic       byteAccess;  // LDRB / STRB
    logic       isLoadStore;
    logic       noRegWrite;  // TST TEQ CMP CMN
    condT       cond;
  } decodeCtrlT;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       pcSrc;
    logic       byteAccess;
    logic [1:0] byteOffset;
    byteMaskT   byteMask;
    logic       setFlags;
    flagsT      flagsNext;
  } memCtrlT;

  typedef struct packed {
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;
    logic       loadByte;
    logic [1:0] byteOffset;
    logic       setFlags;
    flagsT      flagsNext;
  } wbCtrlT;

endpackage

// File: hdl/condUnit.sv
`timescale 1ns/10ps

module condUnit (
  input  armCtrlPkg::condT  cond,
  input  armCtrlPkg::flagsT flags,        // Forwarded flags seen by Execute
  input  armCtrlPkg::flagsT aluFlags,     // This instruction's ALU result flags
  input  logic              shifterCarry,
  input  logic [1:0]        flagWrite,    // [1] NZ, [0] CV
  output logic              condEx,
  output armCtrlPkg::flagsT flagsNext
);

  logic n, z, c, v;

  assign n = flags[armCtrlPkg::flagN];
  assign z = flags[armCtrlPkg::flagZ];
  assign c = flags[armCtrlPkg::flagC];
  assign v = flags[armCtrlPkg::flagV];

  // Condition check
  always_comb begin
    case (cond)
      armCtrlPkg::condEq: condEx = z;
      armCtrlPkg::condNe: condEx = ~z;
      armCtrlPkg::condCs: condEx = c;
      armCtrlPkg::condCc: condEx = ~c;
      armCtrlPkg::condMi: condEx = n;
      armCtrlPkg::condPl: condEx = ~n;
      armCtrlPkg::condVs: condEx = v;
      armCtrlPkg::condVc: condEx = ~v;
      armCtrlPkg::condHi: condEx = c & ~z;        // Unsigned higher
      armCtrlPkg::condLs: condEx = ~c | z;
      armCtrlPkg::condGe: condEx = n == v;        // Signed
      armCtrlPkg::condLt: condEx = n != v;
      armCtrlPkg::condGt: condEx = ~z & (n == v);
      armCtrlPkg::condLe: condEx = z | (n != v);
      armCtrlPkg::condAl: condEx = 1'b1;
      default:            condEx = 1'b0;          // 1111 never
    endcase
  end

  // Next flags
  always_comb begin
    flagsNext = flags;
    if (flagWrite[1]) begin
      flagsNext[armCtrlPkg::flagN] = aluFlags[armCtrlPkg::flagN];
      flagsNext[armCtrlPkg::flagZ] = aluFlags[armCtrlPkg::flagZ];
    end
    if (flagWrite[0]) begin
      flagsNext[armCtrlPkg::flagC] = aluFlags[armCtrlPkg::flagC];
      flagsNext[armCtrlPkg::flagV] = aluFlags[armCtrlPkg::flagV];
    end else if (flagWrite[1]) begin
      flagsNext[armCtrlPkg::flagC] = shifterCarry; // Logical op, V kept
    end
  end

endmodule

// File: hdl/executeStage.sv
`timescale 1ns/10ps

module executeStage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stallE,
  input  logic                   flushE,
  input  armCtrlPkg::decodeCtrlT ctrlD,
  input  armCtrlPkg::flagsT      flagsE,        // Forwarded from M / W / register
  input  armCtrlPkg::flagsT      aluFlagsE,
  input  logic                   shifterCarryE,
  input  logic [1:0]             aluAddrE,      // Low address bits from ALU
  output armCtrlPkg::aluCtrlT    aluControlE,
  output logic                   aluSrcE,
  output logic                   branchTakenE,
  output armCtrlPkg::memCtrlT    ctrlE
);

  armCtrlPkg::decodeCtrlT ctrlRegE;
  logic                   condExE;
  armCtrlPkg::flagsT      flagsNextE;
  armCtrlPkg::byteMaskT   byteMaskE;
  logic                   regWriteGatedE;

  // ==================================================
  // Decode to Execute register
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlRegE <= '0;
    end else if (!stallE) begin
      ctrlRegE <= flushE ? '0 : ctrlD;                // Flush inserts a bubble
    end
  end

  assign aluControlE = ctrlRegE.aluControl;
  assign aluSrcE     = ctrlRegE.aluSrc;

  condUnit uCond (
    .cond         (ctrlRegE.cond),
    .flags        (flagsE),
    .aluFlags     (aluFlagsE),
    .shifterCarry (shifterCarryE),
    .flagWrite    (ctrlRegE.flagWrite),
    .condEx       (condExE),
    .flagsNext    (flagsNextE)
  );

  // Compare class computes flags only
  assign regWriteGatedE = ctrlRegE.regWrite & condExE & ~ctrlRegE.noRegWrite;
  assign branchTakenE   = ctrlRegE.branch & condExE;

  // Store lane enables, little endian lanes
  always_comb begin
    if (!ctrlRegE.isLoadStore) begin
      byteMaskE = '0;
    end else if (ctrlRegE.byteAccess) begin
      byteMaskE = armCtrlPkg::byteMaskT'(1) << aluAddrE; // One lane
    end else begin
      byteMaskE = 4'b1111;                           // Whole word
    end
  end

  // ==================================================
  // Controls toward Memory
  // ==================================================
  always_comb begin
    ctrlE            = '0;
    ctrlE.regWrite   = regWriteGatedE;
    ctrlE.memWrite   = ctrlRegE.memWrite & condExE;
    ctrlE.memtoReg   = ctrlRegE.memtoReg;
    ctrlE.pcSrc      = ctrlRegE.pcSrc & condExE;
    ctrlE.byteAccess = ctrlRegE.byteAccess;
    ctrlE.byteOffset = ctrlRegE.isLoadStore ? aluAddrE : 2'b00;
    ctrlE.byteMask   = byteMaskE;
    ctrlE.setFlags   = (|ctrlRegE.flagWrite) & condExE; // Failed cond leaves flags alone
    ctrlE.flagsNext  = flagsNextE;
  end

endmodule

// File: hdl/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
  input  armCtrlPkg::instrT      instrD,
  output armCtrlPkg::srcSelT     regSrcD,
  output armCtrlPkg::srcSelT     immSrcD,
  output logic                   aluSrcD,
  output armCtrlPkg::decodeCtrlT ctrlD
);

  logic                isDp, isLoadStore, isBranch;
  logic                immBit;  // instr[25]
  logic                loadBit; // L bit at instr[20] in load/store
  logic                upBit;   // U bit picks add or subtract of the offset
  logic                byteBit; // B bit at instr[22]
  logic                sBit;    // Set flags
  armCtrlPkg::aluCtrlT opcode;
  logic [3:0]          rd;
  logic                regWrite, memWrite, memtoReg;
  logic                isArith, isCompare;
  armCtrlPkg::aluCtrlT aluControl;
  logic [1:0]          flagWrite;

  // Instruction fields
  assign immBit  = instrD[25];
  assign loadBit = instrD[20];
  assign sBit    = instrD[20];
  assign upBit   = instrD[23];
  assign byteBit = instrD[22];
  assign opcode  = instrD[24:21];
  assign rd      = instrD[15:12];

  // Class by bits 27:26
  assign isDp        = instrD[27:26] == 2'b00;
  assign isLoadStore = instrD[27:26] == 2'b01;
  assign isBranch    = instrD[27:25] == 3'b101; // 100 is block transfer and stays undecoded

  // Arithmetic opcodes also write C and V
  assign isArith   = opcode inside {armCtrlPkg::opSub, armCtrlPkg::opRsb, armCtrlPkg::opAdd,
                                    armCtrlPkg::opAdc, armCtrlPkg::opSbc, armCtrlPkg::opRsc,
                                    armCtrlPkg::opCmp, armCtrlPkg::opCmn};
  assign isCompare = isDp & (opcode inside {armCtrlPkg::opTst, armCtrlPkg::opTeq,
                                            armCtrlPkg::opCmp, armCtrlPkg::opCmn});

  // ==================================================
  // Main control
  // ==================================================
  always_comb begin
    regSrcD  = 2'b00;
    immSrcD  = 2'b00;
    aluSrcD  = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    memtoReg = 1'b0;
    case (instrD[27:26])
      2'b00: begin                    // Data processing
        aluSrcD  = immBit;             // I bit picks rotated imm8
        regWrite = 1'b1;
      end
      2'b01: begin                    // LDR / STR
        immSrcD = 2'b01;               // imm12 offset
        aluSrcD = ~immBit;             // Here I=0 means immediate
        if (loadBit) begin
          memtoReg = 1'b1;
          regWrite = 1'b1;
        end else begin
          regSrcD  = 2'b10;            // Rd read as store data
          memWrite = 1'b1;
        end
      end
      2'b10: if (immBit) begin        // B
        regSrcD = 2'b01;               // Rn port reads PC
        immSrcD = 2'b10;               // imm24 word offset
        aluSrcD = 1'b1;
      end
      default: ;                       // Coprocessor and SWI space decode as no-op
    endcase
  end

  // ALU opcode and flag write
  always_comb begin
    if (isLoadStore) begin
      aluControl = upBit ? armCtrlPkg::opAdd : armCtrlPkg::opSub; // Rn +/- offset
      flagWrite  = 2'b00;
    end else if (isDp) begin
      aluControl = opcode;
      flagWrite  = {sBit, sBit & isArith}; // Logical ops leave CV to the shifter
    end else begin
      aluControl = armCtrlPkg::opAdd;  // Branch target add
      flagWrite  = 2'b00;
    end
  end

  // ==================================================
  // Control word to Execute
  // ==================================================
  always_comb begin
    ctrlD             = '0;
    ctrlD.aluSrc      = aluSrcD;
    ctrlD.aluControl  = aluControl;
    ctrlD.flagWrite   = flagWrite;
    ctrlD.regWrite    = regWrite;
    ctrlD.memWrite    = memWrite;
    ctrlD.memtoReg    = memtoReg;
    ctrlD.branch      = isBranch;
    ctrlD.pcSrc       = ((rd == 4'hF) & regWrite & ~isCompare) | isBranch; // R15 target
    ctrlD.byteAccess  = isLoadStore & byteBit;
    ctrlD.isLoadStore = isLoadStore;
    ctrlD.noRegWrite  = isCompare;
    ctrlD.cond        = instrD[31:28];
  end

endmodule

// File: hdl/memWbStages.sv
`timescale 1ns/10ps

module memWbStages (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 stallM,
  input  logic                 flushM,
  input  logic                 stallW,
  input  logic                 flushW,
  input  armCtrlPkg::memCtrlT  ctrlE,
  output logic                 memWriteM,
  output logic                 regWriteM,
  output logic                 memtoRegM,
  output armCtrlPkg::byteMaskT byteMaskM,
  output logic                 regWriteW,
  output logic                 memtoRegW,
  output logic                 pcSrcW,
  output logic                 loadByteW,
  output logic [1:0]           byteOffsetW,
  output armCtrlPkg::flagsT    flagsE
);

  armCtrlPkg::memCtrlT ctrlM;
  armCtrlPkg::wbCtrlT  ctrlW;
  armCtrlPkg::wbCtrlT  ctrlWNext;
  armCtrlPkg::flagsT   flagsReg; // Committed NZCV

  // ==================================================
  // Memory stage
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlM <= '0;
    end else if (!stallM) begin
      ctrlM <= flushM ? '0 : ctrlE;
    end
  end

  assign memWriteM = ctrlM.memWrite;
  assign regWriteM = ctrlM.regWrite;
  assign memtoRegM = ctrlM.memtoReg;
  assign byteMaskM = ctrlM.byteMask;

  // Fields carried into Writeback
  always_comb begin
    ctrlWNext            = '0;
    ctrlWNext.regWrite   = ctrlM.regWrite;
    ctrlWNext.memtoReg   = ctrlM.memtoReg;
    ctrlWNext.pcSrc      = ctrlM.pcSrc;
    ctrlWNext.loadByte   = ctrlM.byteAccess & ctrlM.memtoReg;    // LDRB only
    ctrlWNext.byteOffset = ctrlM.byteOffset;
    ctrlWNext.setFlags   = ctrlM.setFlags;
    ctrlWNext.flagsNext  = ctrlM.flagsNext;
  end

  // ==================================================
  // Writeback stage and flags
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlW <= '0;
    end else if (!stallW) begin
      ctrlW <= flushW ? '0 : ctrlWNext;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flagsReg <= '0;
    end else if (ctrlW.setFlags && !stallW) begin
      flagsReg <= ctrlW.flagsNext;                               // Commit one cycle after W
    end
  end

  assign regWriteW   = ctrlW.regWrite;
  assign memtoRegW   = ctrlW.memtoReg;
  assign pcSrcW      = ctrlW.pcSrc;
  assign loadByteW   = ctrlW.loadByte;
  assign byteOffsetW = ctrlW.byteOffset;

  // Youngest pending flags win
  assign flagsE = ctrlM.setFlags ? ctrlM.flagsNext :
                  ctrlW.setFlags ? ctrlW.flagsNext : flagsReg;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --assert -f files.f --top-module tbArmController \
  --Mdir "$BUILD_DIR" -o simTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/simTb" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
  exit 0
else
  exit 1
fi

// File: testbench/armCtrl_asserts.sv
`timescale 1ns/10ps

module armCtrl_asserts (
  input logic                 clk,
  input logic                 rst,
  input logic                 memWriteM,
  input logic                 regWriteM,
  input logic                 branchTakenE,
  input logic                 aluSrcE,
  input armCtrlPkg::aluCtrlT  aluControlE,
  input armCtrlPkg::byteMaskT byteMaskM
);

  // Stage registers are empty right after a reset edge
  resetClears: assert property (@(posedge clk) $past(rst) |-> !memWriteM && !regWriteM)
    else $error("write enable active in the cycle after reset");

  // A branch in Execute adds an immediate offset to the PC
  branchShape: assert property (@(posedge clk) disable iff (rst)
    branchTakenE |-> aluSrcE && aluControlE == armCtrlPkg::opAdd)
    else $error("branch taken without a branch in Execute");

  // A store always enables at least one lane
  storeLanes: assert property (@(posedge clk) disable iff (rst)
    memWriteM |-> byteMaskM != '0)
    else $error("store with an empty byte mask");

endmodule

bind armController armCtrl_asserts uAsserts (
  .clk          (clk),
  .rst          (rst),
  .memWriteM    (memWriteM),
  .regWriteM    (regWriteM),
  .branchTakenE (branchTakenE),
  .aluSrcE      (aluSrcE),
  .aluControlE  (aluControlE),
  .byteMaskM    (byteMaskM)
);

// File: testbench/tbVectors.svh
// Each row holds instr, aluFlagsE, shifterCarryE, addr, stallE, flushE, flushM and flagWrite,
// then the expected branchTakenE, aluControlE, memWriteM, byteMaskM, regWrite, memtoReg,
// pcSrcW, loadByteW, byteOffsetW, regSrcD, immSrcD and aluSrc
typedef struct packed {
  armCtrlPkg::instrT    instr;
  armCtrlPkg::flagsT    aluFlags;
  logic                 carry;
  logic [1:0]           addr;
  logic                 stallE;
  logic                 flushE;
  logic                 flushM;
  logic [1:0]           flagWrite;   // NZ, CV
  logic                 expBranch;
  armCtrlPkg::aluCtrlT  expAluCtrl;
  logic                 expMemWrite;
  armCtrlPkg::byteMaskT expByteMask;
  logic                 expRegWrite; // Same at M and W
  logic                 expMemtoReg;
  logic                 expPcSrc;
  logic                 expLoadByte;
  logic [1:0]           expByteOffset;
  armCtrlPkg::srcSelT   expRegSrc;
  armCtrlPkg::srcSelT   expImmSrc;
  logic                 expAluSrc;   // Seen in Decode and again in Execute
} vecT;

localparam int numVecs = 25;

vecT vecs [numVecs] = '{
  // SUBS, ADDEQ, ADDNE
  '{32'hE0521003, 4'h6, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b11,
    1'b0, 4'h2, 1'b0, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b0},
  '{32'h02844001, 4'h0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b0, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b1},
  '{32'h12855001, 4'h0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b1},
  // CMP, TST, CMN, MOVS
  '{32'hE3510000, 4'h8, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b11,
    1'b0, 4'hA, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b1},
  '{32'hE3110001, 4'h4, 1'b1, 2'd0, 1'b0, 1'b0, 1'b0, 2'b10,
    1'b0, 4'h8, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b1},
  '{32'hE3710001, 4'h1, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b11,
    1'b0, 4'hB, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b1},
  '{32'hE1B06007, 4'h8, 1'b1, 2'd0, 1'b0, 1'b0, 1'b0, 2'b10,
    1'b0, 4'hD, 1'b0, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b0},
  // STR, STRB on all four lanes, STREQ that fails
  '{32'hE5821004, 4'h0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b1, 4'hF, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b10, 2'b01, 1'b1},
  '{32'hE5C21000, 4'h0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b1, 4'h1, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b10, 2'b01, 1'b1},
  '{32'hE5C21000, 4'h0, 1'b0, 2'd1, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b1, 4'h2, 1'b0, 1'b0, 1'b0, 1'b0, 2'd1, 2'b10, 2'b01, 1'b1},
  '{32'hE5C21000, 4'h0, 1'b0, 2'd2, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b1, 4'h4, 1'b0, 1'b0, 1'b0, 1'b0, 2'd2, 2'b10, 2'b01, 1'b1},
  '{32'hE5C21000, 4'h0, 1'b0, 2'd3, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b1, 4'h8, 1'b0, 1'b0, 1'b0, 1'b0, 2'd3, 2'b10, 2'b01, 1'b1},
  '{32'h05821000, 4'h0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b0, 4'hF, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b10, 2'b01, 1'b1},
  // LDR, LDRB, B
  '{32'hE5123004, 4'h0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h2, 1'b0, 4'hF, 1'b1, 1'b1, 1'b0, 1'b0, 2'd0, 2'b00, 2'b01, 1'b1},
  '{32'hE5D23001, 4'h0, 1'b0, 2'd3, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b0, 4'h8, 1'b1, 1'b1, 1'b0, 1'b1, 2'd3, 2'b00, 2'b01, 1'b1},
  '{32'hEA000002, 4'h0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b1, 4'h4, 1'b0, 4'h0, 1'b0, 1'b0, 1'b1, 1'b0, 2'd0, 2'b01, 2'b10, 1'b1},
  // ADD held two extra cycles in Execute while a SUB waits in Decode
  '{32'hE2888001, 4'h0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b0, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b1},
  '{32'hE2499001, 4'h0, 1'b0, 2'd0, 1'b1, 1'b0, 1'b1, 2'b00,
    1'b0, 4'h2, 1'b0, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b1},
  '{32'hE2499001, 4'h0, 1'b0, 2'd0, 1'b1, 1'b0, 1'b1, 2'b00,
    1'b0, 4'h2, 1'b0, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b1},
  '{32'hE2499001, 4'h0, 1'b0, 2'd0, 1'b0, 1'b0, 1'b0, 2'b00,
    1'b0, 4'h2, 1'b0, 4'h0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b1},
  // STR flushed on its way into Execute and the drain behind it
  '{32'hE5821004, 4'h0, 1'b0, 2'd0, 1'b0, 1'b1, 1'b0, 2'b00,
    1'b0, 4'h4, 1'b1, 4'hF, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b10, 2'b01, 1'b1},
  '{32'h00000000, 4'h0, 1'b0, 2'd0, 1'b0, 1'b1, 1'b0, 2'b00,
    1'b0, 4'h0, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b0},
  '{32'h00000000, 4'h0, 1'b0, 2'd0, 1'b0, 1'b1, 1'b0, 2'b00,
    1'b0, 4'h0, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b0},
  '{32'h00000000, 4'h0, 1'b0, 2'd0, 1'b0, 1'b1, 1'b0, 2'b00,
    1'b0, 4'h0, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b0},
  '{32'h00000000, 4'h0, 1'b0, 2'd0, 1'b0, 1'b1, 1'b0, 2'b00,
    1'b0, 4'h0, 1'b0, 4'h0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 2'b00, 2'b00, 1'b0}
};

// File: testbench/tbArmController.sv
`timescale 1ns/10ps

module tbArmController;

  `include "tbVectors.svh"

  logic clk, rst;
  armCtrlPkg::instrT    instrD;
  armCtrlPkg::flagsT    aluFlagsE, flagsE;
  logic                 shifterCarryE;
  logic [1:0]           aluResultE;
  logic                 stallE, stallM, stallW, flushE, flushM, flushW;
  armCtrlPkg::srcSelT   regSrcD, immSrcD;
  logic                 aluSrcD, branchTakenE, aluSrcE;
  armCtrlPkg::aluCtrlT  aluControlE;
  logic                 memWriteM, regWriteM, memtoRegM;
  armCtrlPkg::byteMaskT byteMaskM;
  logic                 regWriteW, memtoRegW, pcSrcW, loadByteW;
  logic [1:0]           byteOffsetW;

  // Row index held in each stage with -1 for a bubble
  int idxE, idxM, idxW;
  logic curStallE, curFlushE, curFlushM;
  logic eSet, mSet, wSet;                          // Pending flag writes
  armCtrlPkg::flagsT eFlags, mFlags, wFlags, flagReg, expFlagsE;
  int errorCount;
  int waitCount;

  armController i_dut (
    .clk (clk), .rst (rst),
    .instrD (instrD), .aluFlagsE (aluFlagsE), .shifterCarryE (shifterCarryE),
    .aluResultE (aluResultE),
    .stallE (stallE), .stallM (stallM), .stallW (stallW),
    .flushE (flushE), .flushM (flushM), .flushW (flushW),
    .regSrcD (regSrcD), .immSrcD (immSrcD), .aluSrcD (aluSrcD),
    .branchTakenE (branchTakenE), .aluControlE (aluControlE), .aluSrcE (aluSrcE),
    .flagsE (flagsE),
    .memWriteM (memWriteM), .regWriteM (regWriteM), .memtoRegM (memtoRegM),
    .byteMaskM (byteMaskM),
    .regWriteW (regWriteW), .memtoRegW (memtoRegW), .pcSrcW (pcSrcW),
    .loadByteW (loadByteW), .byteOffsetW (byteOffsetW)
  );

  always #4 clk = ~clk;                            // 8 ns period

  // ==================================================
  // Flag model
  // ==================================================
  function automatic logic condPass(input armCtrlPkg::condT c, input armCtrlPkg::flagsT f);
    logic n, z, cy, v;
    n  = f[3];
    z  = f[2];
    cy = f[1];
    v  = f[0];
    case (c)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return cy;
      4'h3: return !cy;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return cy && !z;
      4'h9: return !cy || z;
      4'hA: return n == v;
      4'hB: return n != v;
      4'hC: return !z && n == v;
      4'hD: return z || n != v;
      4'hE: return 1'b1;
      default: return 1'b0;                        // Never
    endcase
  endfunction

  function automatic armCtrlPkg::flagsT flagsAfter(input armCtrlPkg::flagsT f,
      input armCtrlPkg::flagsT alu, input logic sc, input logic [1:0] fw);
    armCtrlPkg::flagsT r;
    r = f;
    if (fw[1]) r[3:2] = alu[3:2];
    if (fw[0]) r[1:0] = alu[1:0];
    else if (fw[1]) r[1] = sc;                     // Shifter carry with V kept
    return r;
  endfunction

  task automatic failRun();
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      errorCount++;
      $display("error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      failRun();
    end
  endtask

  // Advance the model over one clock edge
  task automatic advanceModel(input int row);
    if (wSet) flagReg = wFlags;
    wSet   = mSet;
    wFlags = mFlags;
    idxW   = idxM;
    if (curFlushM) begin
      idxM = -1;
      mSet = 1'b0;
    end else begin
      idxM   = idxE;
      mSet   = eSet;
      mFlags = eFlags;
    end
    if (!curStallE) idxE = curFlushE ? -1 : row;
  endtask

  task automatic driveRow(input int row);
    instrD    = vecs[row].instr;
    stallE    = vecs[row].stallE;
    flushE    = vecs[row].flushE;
    flushM    = vecs[row].flushM;
    curStallE = vecs[row].stallE;
    curFlushE = vecs[row].flushE;
    curFlushM = vecs[row].flushM;
    // Datapath results belong to whatever sits in Execute
    aluFlagsE     = (idxE >= 0) ? vecs[idxE].aluFlags : 4'h0;
    shifterCarryE = (idxE >= 0) ? vecs[idxE].carry : 1'b0;
    aluResultE    = (idxE >= 0) ? vecs[idxE].addr : 2'd0;
  endtask

  // Decode outputs follow the word on instrD, -1 means an all-zero word
  task automatic checkDecode(input int row);
    vecT r;
    r = '0;
    if (row >= 0) r = vecs[row];
    checkValue("regSrcD", 32'(regSrcD), 32'(r.expRegSrc));
    checkValue("immSrcD", 32'(immSrcD), 32'(r.expImmSrc));
    checkValue("aluSrcD", 32'(aluSrcD), 32'(r.expAluSrc));
  endtask

  task automatic checkStages();
    vecT r;
    r = '0;
    expFlagsE = mSet ? mFlags : (wSet ? wFlags : flagReg);
    checkValue("flagsE", 32'(flagsE), 32'(expFlagsE));
    if (idxE >= 0) r = vecs[idxE];
    checkValue("branchTakenE", 32'(branchTakenE), 32'(r.expBranch));
    checkValue("aluControlE", 32'(aluControlE), 32'(r.expAluCtrl));
    checkValue("aluSrcE", 32'(aluSrcE), 32'(r.expAluSrc));
    eSet   = (idxE >= 0) && condPass(r.instr[31:28], expFlagsE) && (r.flagWrite != 2'b00);
    eFlags = flagsAfter(expFlagsE, r.aluFlags, r.carry, r.flagWrite);
    r = '0;
    if (idxM >= 0) r = vecs[idxM];
    checkValue("memWriteM", 32'(memWriteM), 32'(r.expMemWrite));
    checkValue("byteMaskM", 32'(byteMaskM), 32'(r.expByteMask));
    checkValue("regWriteM", 32'(regWriteM), 32'(r.expRegWrite));
    checkValue("memtoRegM", 32'(memtoRegM), 32'(r.expMemtoReg));
    r = '0;
    if (idxW >= 0) r = vecs[idxW];
    checkValue("regWriteW", 32'(regWriteW), 32'(r.expRegWrite));
    checkValue("memtoRegW", 32'(memtoRegW), 32'(r.expMemtoReg));
    checkValue("pcSrcW", 32'(pcSrcW), 32'(r.expPcSrc));
    checkValue("loadByteW", 32'(loadByteW), 32'(r.expLoadByte));
    checkValue("byteOffsetW", 32'(byteOffsetW), 32'(r.expByteOffset));
  endtask

  // ==================================================
  // Reset and stimulus
  // ==================================================
  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
  end

  initial begin
    #20000;
    $display("timeout: the run did not finish in time");
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    instrD        = '0;
    aluFlagsE     = '0;
    shifterCarryE = 1'b0;
    aluResultE    = 2'd0;
    stallE        = 1'b0;
    stallM        = 1'b0;
    stallW        = 1'b0;
    flushE        = 1'b1;                          // Bubbles until the table starts
    flushM        = 1'b0;
    flushW        = 1'b0;
    idxE          = -1;
    idxM          = -1;
    idxW          = -1;
    curStallE     = 1'b0;
    curFlushE     = 1'b1;
    curFlushM     = 1'b0;
    eSet          = 1'b0;
    mSet          = 1'b0;
    wSet          = 1'b0;
    eFlags        = '0;
    mFlags        = '0;
    wFlags        = '0;
    flagReg       = '0;
    errorCount    = 0;
    waitCount     = 0;
    // Wait for reset release
    while (1'b1) begin
      @(negedge clk);
      if (!rst) break;
      waitCount++;
      if (waitCount > 20) begin
        $display("timeout: reset was never released");
        failRun();
      end
    end
    checkDecode(-1);
    checkStages();                                 // Everything idle after reset
    for (int t = 0; t < numVecs; t++) begin
      @(posedge clk);
      advanceModel(t - 1);
      #1 driveRow(t);
      @(negedge clk);
      checkDecode(t);
      checkStages();
    end
    if (errorCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
